// File: rtl/decision_ctr_defines.svh
`ifndef DECISION_CTR_DEFINES_SVH
`define DECISION_CTR_DEFINES_SVH

// number of test-pattern records collected into one frame.
`define DECISION_NUMS 8

// width of one error-polynomial degree record.
`define BIT_WIDTH_DEG 2

// width of one error-count record.
`define BIT_WIDTH_ERR_CNT 2

// record counter width able to hold 0 to DECISION_NUMS.
`define ENTRY_CNT_WIDTH 4

`endif

// File: rtl/decision_ctr_pkg.sv
`default_nettype none

package decision_ctr_pkg;

    // holding stage and output handshake states.
    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0, // holding stage free.
        ST_HELD  = 2'd1, // frame held, waiting for out_req.
        ST_ACK   = 2'd2  // ack raised, waiting for out_req to drop.
    } xfer_state_t;

    // operation applied to the counter and both banks in one cycle.
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_SHIFT = 2'd1, // one record into the loading stage.
        OP_XFER  = 2'd2  // loading stage copied to holding stage.
    } bank_op_t;

endpackage

`default_nettype wire

// File: rtl/entry_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "decision_ctr_defines.svh"

module entry_counter
    import decision_ctr_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic en,
    input  bank_op_t  bank_op,
    output logic      frame_full
);

    localparam logic [`ENTRY_CNT_WIDTH-1:0] last_entry =
        `ENTRY_CNT_WIDTH'(`DECISION_NUMS - 1);

    logic [`ENTRY_CNT_WIDTH-1:0] count; // records in the loading stage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count      <= '0;
            frame_full <= 1'b0;
        end else if (en) begin
            case (bank_op)
                OP_SHIFT: begin
                    count <= count + 1'b1;
                    if (count == last_entry) begin
                        frame_full <= 1'b1; // set with the last record.
                    end
                end
                OP_XFER: begin
                    count      <= '0;
                    frame_full <= 1'b0;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/info_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "decision_ctr_defines.svh"

module info_bank
    import decision_ctr_pkg::*;
#(
    parameter int info_width = 2
) (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic                                en,
    input  bank_op_t                                 bank_op,
    input  wire logic [info_width-1:0]               in_info,
    output logic [`DECISION_NUMS*info_width-1:0]     out_info
);

    localparam int frame_width = `DECISION_NUMS * info_width;

    logic [frame_width-1:0] load_q; // serial loading stage.
    logic [frame_width-1:0] hold_q; // parallel holding stage.

    // new records enter at the top and walk down, so after a full frame
    // the first record sits in slice 0.
    always_ff @(posedge clk) begin
        if (en && (bank_op == OP_SHIFT)) begin
            load_q <= {in_info, load_q[frame_width-1:info_width]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_q <= '0;
        end else if (en && (bank_op == OP_XFER)) begin
            hold_q <= load_q; // stays put until the next transfer.
        end
    end

    assign out_info = hold_q;

endmodule

`default_nettype wire

// File: rtl/decision_xfer_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module decision_xfer_fsm
    import decision_ctr_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic en,
    input  wire logic get_val,
    input  wire logic frame_full,
    input  wire logic out_req,
    output logic      out_ack,
    output bank_op_t  bank_op
);

    xfer_state_t state;
    xfer_state_t next_state;

    // shift and transfer never coincide since shift needs a free slot
    // and transfer needs a full loading stage.
    always_comb begin
        bank_op = OP_IDLE;
        if (en) begin
            if (get_val && !frame_full) begin
                bank_op = OP_SHIFT;
            end else if (frame_full && (state == ST_EMPTY)) begin
                bank_op = OP_XFER;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_EMPTY: begin
                if (bank_op == OP_XFER) begin
                    next_state = ST_HELD; // frame lands in holding stage.
                end
            end
            ST_HELD: begin
                if (out_req) begin
                    next_state = ST_ACK;
                end
            end
            ST_ACK: begin
                if (!out_req) begin
                    next_state = ST_EMPTY; // consumer done with the frame.
                end
            end
            default: begin
                next_state = ST_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_EMPTY;
            out_ack <= 1'b0;
        end else if (en) begin
            state   <= next_state;
            out_ack <= (next_state == ST_ACK); // high exactly in ST_ACK.
        end
    end

endmodule

`default_nettype wire

// File: rtl/decision_ctr.sv
`timescale 1ns/1ns
`default_nettype none

`include "decision_ctr_defines.svh"

module decision_ctr
    import decision_ctr_pkg::*;
(
    input  wire logic                                          clk,
    input  wire logic                                          arst_n,
    input  wire logic                                          en,
    input  wire logic                                          get_val,
    input  wire logic [`BIT_WIDTH_DEG-1:0]                     in_deg,
    input  wire logic [`BIT_WIDTH_ERR_CNT-1:0]                 in_err_cnt,
    input  wire logic                                          out_req,
    output logic                                               load_ready,
    output logic                                               out_ack,
    output logic [`DECISION_NUMS*`BIT_WIDTH_DEG-1:0]           out_deg,
    output logic [`DECISION_NUMS*`BIT_WIDTH_ERR_CNT-1:0]       out_err_cnt
);

    bank_op_t bank_op;   // shared by both banks so slices stay aligned.
    logic     frame_full;

    assign load_ready = ~frame_full; // loading stage can take a record.

    decision_xfer_fsm xfer_fsm_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .get_val    (get_val),
        .frame_full (frame_full),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .bank_op    (bank_op)
    );

    entry_counter entry_counter_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .bank_op    (bank_op),
        .frame_full (frame_full)
    );

    // degree path.
    info_bank #(
        .info_width (`BIT_WIDTH_DEG)
    ) deg_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .bank_op  (bank_op),
        .in_info  (in_deg),
        .out_info (out_deg)
    );

    // error-count path.
    info_bank #(
        .info_width (`BIT_WIDTH_ERR_CNT)
    ) err_cnt_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (en),
        .bank_op  (bank_op),
        .in_info  (in_err_cnt),
        .out_info (out_err_cnt)
    );

endmodule

`default_nettype wire

// File: verification/decision_ctr_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "decision_ctr_defines.svh"

module decision_ctr_tb;

    localparam int deg_frame_w    = `DECISION_NUMS * `BIT_WIDTH_DEG;
    localparam int err_frame_w    = `DECISION_NUMS * `BIT_WIDTH_ERR_CNT;
    localparam int overlap_frames = 40;
    localparam int freeze_frames  = 20;
    localparam int ack_timeout    = 200; // cycles allowed per handshake phase.

    logic                            clk;
    logic                            arst_n;
    logic                            en;
    logic                            get_val;
    logic [`BIT_WIDTH_DEG-1:0]       in_deg;
    logic [`BIT_WIDTH_ERR_CNT-1:0]   in_err_cnt;
    logic                            out_req;
    logic                            load_ready;
    logic                            out_ack;
    logic [deg_frame_w-1:0]          out_deg;
    logic [err_frame_w-1:0]          out_err_cnt;

    integer seed = 32'h8552_19a0;
    int     error_count    = 0;
    int     timeout_count  = 0;
    int     accepted_total = 0;
    int     pend_count     = 0;

    logic [deg_frame_w-1:0] pend_deg;            // frame being collected by the model.
    logic [err_frame_w-1:0] pend_err;
    logic [deg_frame_w-1:0] exp_deg_q[$];        // completed frames, oldest first.
    logic [err_frame_w-1:0] exp_err_q[$];

    logic en_at_edge;
    logic ack_prev;
    logic ready_prev;                            // load_ready as it stood before the edge.
    logic freeze_armed = 1'b0;

    decision_ctr decision_ctr_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .en          (en),
        .get_val     (get_val),
        .in_deg      (in_deg),
        .in_err_cnt  (in_err_cnt),
        .out_req     (out_req),
        .load_ready  (load_ready),
        .out_ack     (out_ack),
        .out_deg     (out_deg),
        .out_err_cnt (out_err_cnt)
    );

    always #50 clk = ~clk;

    // model of frame collection where record k of a frame lands in slice k.
    always @(posedge clk) begin
        if (arst_n && en && get_val && ready_prev) begin
            pend_deg[pend_count*`BIT_WIDTH_DEG +: `BIT_WIDTH_DEG]         = in_deg;
            pend_err[pend_count*`BIT_WIDTH_ERR_CNT +: `BIT_WIDTH_ERR_CNT] = in_err_cnt;
            pend_count++;
            accepted_total++;
            if (pend_count == `DECISION_NUMS) begin
                exp_deg_q.push_back(pend_deg);
                exp_err_q.push_back(pend_err);
                pend_count = 0;
            end
        end
    end

    // with en low across an edge, nothing visible may move.
    always @(posedge clk) begin
        en_at_edge = en;
    end

    always @(negedge clk) begin
        if (freeze_armed && !en_at_edge) begin
            check_value("enable_freeze_ack", 32'(ack_prev), 32'(out_ack));
            check_value("enable_freeze_ready", 32'(ready_prev), 32'(load_ready));
        end
        ack_prev     = out_ack;
        ready_prev   = load_ready;
        freeze_armed = arst_n;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_records(input int n, input bit with_gaps, input bit with_freeze);
        int          target;
        int          cycles;
        logic [31:0] rnd;
        target = accepted_total + n;
        cycles = 0;
        @(negedge clk);
        while (accepted_total < target && cycles < n * 20 + 200) begin
            rnd        = $random(seed);
            in_deg     = rnd[`BIT_WIDTH_DEG-1:0];
            in_err_cnt = rnd[8 +: `BIT_WIDTH_ERR_CNT];
            get_val    = !with_gaps || (rnd[17:16] != 2'b00);   // about one gap in four.
            en         = !with_freeze || (rnd[22:20] != 3'b000); // about one freeze in eight.
            @(negedge clk);
            cycles++;
        end
        get_val = 1'b0;
        en      = 1'b1;
        assert (accepted_total >= target) else begin
            $display("timeout: only %0d of %0d records were accepted",
                     n - (target - accepted_total), n);
            timeout_count++;
        end
    endtask

    task automatic strobe_while_blocked(input int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rnd        = $random(seed);
            in_deg     = rnd[`BIT_WIDTH_DEG-1:0];
            in_err_cnt = rnd[8 +: `BIT_WIDTH_ERR_CNT];
            get_val    = 1'b1;
            check_value("backpressure_ready", 32'd0, 32'(load_ready));
        end
        @(negedge clk);
        get_val = 1'b0;
    endtask

    task automatic wait_ready_low(input string name);
        int waited;
        waited = 0;
        while (load_ready && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        assert (!load_ready) else begin
            $display("timeout: load_ready never went low in %s", name);
            timeout_count++;
        end
    endtask

    task automatic consume_frame(input string name);
        int                     waited;
        logic [deg_frame_w-1:0] exp_deg;
        logic [err_frame_w-1:0] exp_err;
        @(negedge clk);
        out_req = 1'b1;
        waited  = 0;
        while (!out_ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        assert (out_ack) else begin
            $display("timeout: out_ack never rose in %s", name);
            timeout_count++;
        end
        if (out_ack) begin
            assert (exp_deg_q.size() > 0) else begin
                $display("%s received a frame that the model never completed", name);
                error_count++;
            end
            if (exp_deg_q.size() > 0) begin
                exp_deg = exp_deg_q.pop_front();
                exp_err = exp_err_q.pop_front();
                check_value({name, "_deg"}, 32'(exp_deg), 32'(out_deg));
                check_value({name, "_err_cnt"}, 32'(exp_err), 32'(out_err_cnt));
                @(negedge clk);                       // frame must hold while acked.
                check_value({name, "_deg_stable"}, 32'(exp_deg), 32'(out_deg));
                check_value({name, "_err_cnt_stable"}, 32'(exp_err), 32'(out_err_cnt));
            end
        end
        out_req = 1'b0;
        waited  = 0;
        while (out_ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        assert (!out_ack) else begin
            $display("timeout: out_ack never fell in %s", name);
            timeout_count++;
        end
    endtask

    task automatic consume_frames(input int n, input string name);
        for (int i = 0; i < n; i++) begin
            repeat (i % 4) @(negedge clk); // uneven consumer pace.
            consume_frame(name);
        end
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        en         = 1'b1;
        get_val    = 1'b0;
        in_deg     = '0;
        in_err_cnt = '0;
        out_req    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        @(negedge clk);
        check_value("reset_ack", 32'd0, 32'(out_ack));
        check_value("reset_ready", 32'd1, 32'(load_ready));
        check_value("reset_deg", 32'd0, 32'(out_deg));
        check_value("reset_err_cnt", 32'd0, 32'(out_err_cnt));

        load_records(`DECISION_NUMS, 1'b0, 1'b0);
        consume_frame("single_frame");

        // consumer idle while two frames fill, then strobes bounce off.
        load_records(2 * `DECISION_NUMS, 1'b0, 1'b0);
        wait_ready_low("backpressure");
        strobe_while_blocked(12);
        check_value("backpressure_frames", 32'd2, 32'(exp_deg_q.size()));
        check_value("backpressure_pending", 32'd0, 32'(pend_count));
        consume_frame("backpressure_first");
        consume_frame("backpressure_second");
        check_value("backpressure_left", 32'd0, 32'(exp_deg_q.size()));

        fork
            load_records(overlap_frames * `DECISION_NUMS, 1'b1, 1'b0);
            consume_frames(overlap_frames, "overlap");
        join

        fork
            load_records(freeze_frames * `DECISION_NUMS, 1'b1, 1'b1);
            consume_frames(freeze_frames, "enable_freeze");
        join

        check_value("final_frames_left", 32'd0, 32'(exp_deg_q.size()));
        check_value("final_pending", 32'd0, 32'(pend_count));

        $display("check failures: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: decision_ctr.f
+incdir+rtl
rtl/decision_ctr_pkg.sv
rtl/entry_counter.sv
rtl/info_bank.sv
rtl/decision_xfer_fsm.sv
rtl/decision_ctr.sv
verification/decision_ctr_tb.sv

// File: Makefile
# Verilator build and run for the decision-information controller.

VERILATOR ?= verilator
TOP       ?= decision_ctr_tb
FILE_LIST ?= decision_ctr.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# the run fails unless the simulation prints the pass message on a line of its own
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
